/* Bender.yml */
package:
  name: eeprom_ctrl

sources:
  - eeprom_pkg.sv
  - twi_pkg.sv
  - twi_bit_engine.sv
  - eeprom_ctrl.sv
  - eeprom_top.sv
  - target: simulation
    files:
      - tb_eeprom_model.sv
      - tb_eeprom_top.sv

/* eeprom_ctrl.sv */
`timescale 1ns/1ps

module eeprom_ctrl import eeprom_pkg::*, twi_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     wr,
    input  logic     rd,
    input  ee_addr_t addr,
    input  ee_data_t wdata,
    output ee_data_t rdata,
    output logic     ack,
    output twi_cmd_t cmd,
    output logic     cmd_start,
    input  logic     done,
    input  ee_data_t rx_byte
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_ACK
    } ctrl_state_t;

    ctrl_state_t state;
    ee_req_t     req;
    ee_req_t     host_req;
    ee_step_t    step;
    ee_step_t    last_step;
    ee_data_t    rx_hold;

    logic start_req;
    logic step_done;
    logic seq_end;

    function automatic ee_data_t ctrl_byte(ee_req_t r, logic dir);
        ee_blk_t blk;
        blk = r.addr[EE_ADDR_W-1:EE_DATA_W];
        return {EE_DEVICE_CODE, blk, dir};
    endfunction

    // bus op for one step of the transaction
    function automatic twi_cmd_t cmd_for(ee_req_t r, ee_step_t s);
        twi_cmd_t c;
        c.op   = STOP;
        c.data = '0;
        case (s)
            3'd0:
                c.op = START;
            3'd1:
            begin
                c.op   = WRITE_BYTE;
                c.data = ctrl_byte(r, EE_DIR_WRITE);   // dummy write on reads too
            end
            3'd2:
            begin
                c.op   = WRITE_BYTE;
                c.data = r.addr[EE_DATA_W-1:0];
            end
            3'd3:
            begin
                if (r.rd)
                    c.op = START;                      // repeated start
                else
                begin
                    c.op   = WRITE_BYTE;
                    c.data = r.wdata;
                end
            end
            3'd4:
            begin
                if (r.rd)
                begin
                    c.op   = WRITE_BYTE;
                    c.data = ctrl_byte(r, EE_DIR_READ);
                end
            end
            3'd5:
            begin
                if (r.rd)
                    c.op = READ_BYTE;
            end
            default:
                c.op = STOP;
        endcase
        return c;
    endfunction

    assign host_req  = '{addr: addr, wdata: wdata, rd: ~wr};   // wr wins
    assign last_step = req.rd ? EE_RD_LAST : EE_WR_LAST;

    assign start_req = (state == S_IDLE) && (wr || rd);
    assign step_done = (state == S_BUSY) && done;
    assign seq_end   = step_done && (step == last_step);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            step      <= '0;
            cmd_start <= 1'b0;
            ack       <= 1'b0;
            rdata     <= '0;
        end
        else
        begin
            cmd_start <= 1'b0;
            ack       <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (start_req)
                    begin
                        step      <= '0;
                        cmd_start <= 1'b1;
                        state     <= S_BUSY;
                    end
                end
                S_BUSY:
                begin
                    if (seq_end)
                    begin
                        ack   <= 1'b1;
                        state <= S_ACK;
                        if (req.rd)
                            rdata <= rx_hold;
                    end
                    else if (step_done)
                    begin
                        step      <= ee_step_t'(step + 1'b1);
                        cmd_start <= 1'b1;
                    end
                end
                default:
                    state <= S_IDLE;    // ack cycle
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (start_req)
        begin
            req <= host_req;
            cmd <= cmd_for(host_req, 3'd0);
        end
        else if (step_done && !seq_end)
            cmd <= cmd_for(req, ee_step_t'(step + 1'b1));
        if (step_done && cmd.op == READ_BYTE)
            rx_hold <= rx_byte;
    end

endmodule

/* eeprom_pkg.sv */
package eeprom_pkg;

    localparam int EE_ADDR_W = 11;
    localparam int EE_DATA_W = 8;
    localparam int EE_BLK_W  = EE_ADDR_W - EE_DATA_W;    // block select bits in the control byte

    typedef logic [EE_ADDR_W-1:0] ee_addr_t;
    typedef logic [EE_DATA_W-1:0] ee_data_t;
    typedef logic [EE_BLK_W-1:0]  ee_blk_t;

    // control byte is {code, block, r/w}
    localparam logic [3:0] EE_DEVICE_CODE = 4'b1010;
    localparam logic       EE_DIR_WRITE   = 1'b0;
    localparam logic       EE_DIR_READ    = 1'b1;

    // index into the bus op list of one transaction
    typedef logic [2:0] ee_step_t;

    // byte write: start, ctrl, addr, data, stop
    localparam ee_step_t EE_WR_LAST = 3'd4;
    // random read: start, ctrl, addr, start, ctrl, read, stop
    localparam ee_step_t EE_RD_LAST = 3'd6;

    // request latched from the host strobes
    typedef struct packed {
        ee_addr_t addr;
        ee_data_t wdata;
        logic     rd;       // 0 = byte write
    } ee_req_t;

endpackage

/* eeprom_top.sv */
`timescale 1ns/1ps

module eeprom_top import eeprom_pkg::*, twi_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     wr,
    input  logic     rd,
    input  ee_addr_t addr,
    input  ee_data_t wdata,
    output ee_data_t rdata,
    output logic     ack,
    output logic     SCL,
    inout  wire      SDA
);

    twi_cmd_t cmd;
    logic     cmd_start;
    logic     done;
    ee_data_t rx_byte;
    logic     sda_out;
    logic     sda_oe;
    logic     sda_in;

    eeprom_ctrl u_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .ack       (ack),
        .cmd       (cmd),
        .cmd_start (cmd_start),
        .done      (done),
        .rx_byte   (rx_byte)
    );

    twi_bit_engine u_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_start (cmd_start),
        .done      (done),
        .rx_byte   (rx_byte),
        .scl       (SCL),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

    // open drain, only ever pulls low
    assign SDA    = (sda_oe && !sda_out) ? 1'b0 : 1'bz;
    assign sda_in = SDA;

endmodule

/* project.f */
eeprom_pkg.sv
twi_pkg.sv
twi_bit_engine.sv
eeprom_ctrl.sv
eeprom_top.sv
tb_eeprom_model.sv
tb_eeprom_top.sv

/* tb_eeprom_model.sv */
`timescale 1ns/1ps

module tb_eeprom_model import eeprom_pkg::*;
(
    input  logic SCL,
    inout  wire  SDA
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_DATA,
        M_RDCTL,
        M_SEND,
        M_DONE
    } mode_t;

    ee_data_t mem [0:2047];
    mode_t    mode     = M_IDLE;
    int       cnt      = 0;         // SCL rising edges since start or last byte
    ee_data_t rx       = '0;
    ee_data_t tx       = '0;
    ee_blk_t  blk      = '0;
    ee_addr_t ptr      = '0;
    logic     pull_low = 1'b0;
    logic     scl_q    = 1'b1;
    logic     sda_q    = 1'b1;

    assign SDA = pull_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;     // erased
    end

    // a written byte is complete, ack it unless the code is foreign
    task automatic take_byte();
        case (mode)
            M_CTRL:
            begin
                if (rx[7:4] != EE_DEVICE_CODE)
                    mode = M_DONE;
                else
                begin
                    blk      = rx[3:1];
                    mode     = rx[0] ? M_RDCTL : M_ADDR;
                    pull_low = 1'b1;
                end
            end
            M_ADDR:
            begin
                ptr      = {blk, rx};
                mode     = M_DATA;
                pull_low = 1'b1;
            end
            M_DATA:
            begin
                mem[ptr] = rx;
                mode     = M_DONE;
                pull_low = 1'b1;
            end
            default:
                pull_low = 1'b0;
        endcase
    endtask

    always @(SCL or SDA)
    begin
        if (SCL === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && SDA === 1'b0)
        begin
            mode     = M_CTRL;      // start or repeated start
            cnt      = 0;
            pull_low = 1'b0;
        end
        else if (SCL === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && SDA === 1'b1)
        begin
            mode     = M_IDLE;
            cnt      = 0;
            pull_low = 1'b0;
        end
        else if (SCL === 1'b1 && scl_q === 1'b0 && mode != M_IDLE)
        begin
            cnt++;
            if (cnt <= 8)
                rx = {rx[6:0], (SDA !== 1'b0)};
        end
        else if (SCL === 1'b0 && scl_q === 1'b1 && mode == M_SEND)
        begin
            if (cnt >= 1 && cnt <= 7)
                pull_low = ~tx[7 - cnt];
            else if (cnt == 8)
                pull_low = 1'b0;    // master answers nack
            else if (cnt == 9)
            begin
                mode = M_IDLE;
                cnt  = 0;
            end
        end
        else if (SCL === 1'b0 && scl_q === 1'b1 && mode != M_IDLE)
        begin
            if (cnt == 8)
                take_byte();
            else if (cnt == 9)
            begin
                pull_low = 1'b0;
                cnt      = 0;
                if (mode == M_RDCTL)
                begin
                    tx       = mem[ptr];
                    pull_low = ~tx[7];
                    mode     = M_SEND;
                end
            end
        end
        scl_q = SCL;
        sda_q = SDA;
    end

endmodule

/* tb_eeprom_top.sv */
`timescale 1ns/1ps

module tb_eeprom_top import eeprom_pkg::*, twi_pkg::*;
();

    localparam int CLK_NS   = 4;
    localparam int RD_BITS  = 40;   // SCL bits in one random read
    localparam int ACK_WAIT = RD_BITS * 4 * TWI_QUARTER * 2;

    typedef struct {
        string    name;
        logic     rd;
        logic     poke;     // extra strobes while busy
        ee_addr_t addr;
        ee_data_t wdata;
        ee_data_t exp;
    } entry_t;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    ee_addr_t    addr;
    ee_data_t    wdata;
    ee_data_t    rdata;
    logic        ack;
    logic        SCL;
    wire         SDA;

    entry_t      tbl[$];
    ee_data_t    shadow [0:2047];
    logic [15:0] lfsr      = 16'd3224;
    int          errors    = 0;
    int          checks    = 0;
    logic        tbl_ready = 1'b0;

    pullup (SDA);

    eeprom_top DUT (.*);

    tb_eeprom_model u_model (
        .SCL (SCL),
        .SDA (SDA)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] take_bits(int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_data(string name, ee_data_t exp, ee_data_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Fail %s: expected %02h, got %02h", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Fail %s: expected %b, got %b", name, exp, act);
        end
    endtask

    // expected read value comes from the shadow at table build time
    task automatic add_entry(string name, logic is_rd, ee_addr_t a, ee_data_t d, logic poke);
        entry_t e;
        e = '{name: name, rd: is_rd, poke: poke, addr: a, wdata: d, exp: shadow[a]};
        if (!is_rd)
            shadow[a] = d;
        tbl.push_back(e);
    endtask

    task automatic run_entry(entry_t t);
        logic got;
        got = 1'b0;
        @(posedge CLK);
        #1;
        addr  = t.addr;
        wdata = t.wdata;
        wr    = ~t.rd;
        rd    = t.rd;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        if (t.poke)
        begin
            repeat (5) @(posedge CLK);
            #1;
            wr    = 1'b1;
            rd    = 1'b1;
            addr  = t.addr ^ 11'h400;   // other block, must stay erased
            wdata = ~t.wdata;
            @(posedge CLK);
            #1;
            wr = 1'b0;
            rd = 1'b0;
        end
        for (int n = 0; n < ACK_WAIT && !got; n++)
        begin
            @(negedge CLK);
            got = ack;
        end
        if (!got)
        begin
            errors++;
            $display("The DUT gave no ack for test %s", t.name);
        end
        else
        begin
            if (t.rd)
                check_data(t.name, t.exp, rdata);
            @(negedge CLK);
            check_bit({t.name, "_single_ack"}, 1'b0, ack);
        end
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_NS / 2) CLK = ~CLK;
    end

    initial
    begin
        longint limit;
        wait (tbl_ready);
        limit = longint'(tbl.size()) * RD_BITS * 4 * TWI_QUARTER * CLK_NS * 2;
        #(limit);
        $display("Watchdog expired after %0d ns, the tests did not finish", limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        ee_addr_t a;
        ee_data_t d;
        logic     r;
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'hFF;
        add_entry("wr_basic", 1'b0, 11'h123, 8'h5A, 1'b0);
        add_entry("rd_basic", 1'b1, 11'h123, 8'h00, 1'b0);
        add_entry("wr_blk0", 1'b0, 11'h045, 8'h10, 1'b0);
        add_entry("wr_blk2", 1'b0, 11'h245, 8'h32, 1'b0);
        add_entry("wr_blk7", 1'b0, 11'h745, 8'h87, 1'b0);
        add_entry("rd_blk0", 1'b1, 11'h045, 8'h00, 1'b0);
        add_entry("rd_blk2", 1'b1, 11'h245, 8'h00, 1'b0);
        add_entry("rd_blk7", 1'b1, 11'h745, 8'h00, 1'b0);
        add_entry("rd_blk5_erased", 1'b1, 11'h545, 8'h00, 1'b0);
        add_entry("rd_erased_top", 1'b1, 11'h7FF, 8'h00, 1'b0);
        add_entry("wr_busy", 1'b0, 11'h300, 8'hC3, 1'b1);
        add_entry("rd_busy", 1'b1, 11'h300, 8'h00, 1'b1);
        add_entry("rd_poked", 1'b1, 11'h700, 8'h00, 1'b0);
        for (int i = 0; i < 16; i++)
        begin
            r = 1'(take_bits(1));
            a = {3'(take_bits(3)), 6'h14, 2'(take_bits(2))};   // small set, reads hit writes
            d = 8'(take_bits(8));
            add_entry($sformatf("rand_%0d", i), r, a, d, 1'b0);
        end
        tbl_ready = 1'b1;
        repeat (3) @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(negedge CLK);
        check_bit("reset_scl", 1'b1, SCL);
        check_bit("reset_sda", 1'b1, SDA);
        check_bit("reset_ack", 1'b0, ack);
        check_data("reset_rdata", 8'h00, rdata);
        foreach (tbl[i])
            run_entry(tbl[i]);
        $display("errors: %0d in %0d checks over %0d tests", errors, checks, tbl.size());
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* twi_bit_engine.sv */
`timescale 1ns/1ps

module twi_bit_engine import eeprom_pkg::*, twi_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  twi_cmd_t cmd,
    input  logic     cmd_start,
    output logic     done,
    output ee_data_t rx_byte,
    output logic     scl,
    output logic     sda_out,
    output logic     sda_oe,
    input  logic     sda_in
);

    typedef enum logic {
        ENG_IDLE,
        ENG_RUN
    } eng_state_t;

    eng_state_t state;
    twi_op_t    op;
    ee_data_t   shreg;      // tx bits out of [7], rx bits into [0]
    twi_qcnt_t  qcnt;
    twi_phase_t phase;
    twi_bit_t   bit_idx;
    twi_line_t  line_q;

    logic       step_end;
    logic       last_phase;
    logic       last_bit;
    twi_phase_t phase_nxt;
    twi_bit_t   bit_nxt;
    ee_data_t   shreg_nxt;

    // line levels for one quarter step of an op
    function automatic twi_line_t line_for(
        twi_op_t    o,
        twi_phase_t ph,
        twi_bit_t   b,
        logic       txb,
        logic       scl_now
    );
        twi_line_t l;
        l.scl = (ph == 2'd1) || (ph == 2'd2);   // low, high, high, low
        l.oe  = 1'b0;
        l.out = 1'b1;
        case (o)
            START:
            begin
                if (ph == 2'd0)
                    l.scl = scl_now;            // release SDA first, clock untouched
                if (ph >= 2'd2)
                begin
                    l.oe  = 1'b1;               // SDA falls with SCL high
                    l.out = 1'b0;
                end
            end
            STOP:
            begin
                l.scl = (ph != 2'd0);
                l.oe  = (ph < 2'd2);            // SDA rises with SCL high
                l.out = ~l.oe;
            end
            WRITE_BYTE:
            begin
                if (b != TWI_LAST_BIT)
                begin
                    l.oe  = 1'b1;
                    l.out = txb;
                end
            end
            default:
            begin
                if (b == TWI_LAST_BIT)
                    l.oe = 1'b1;                // nack, out stays high
            end
        endcase
        return l;
    endfunction

    assign step_end   = (qcnt == TWI_QCNT_LAST);
    assign last_phase = (phase == TWI_LAST_PHASE);
    assign last_bit   = (op == START) || (op == STOP) || (bit_idx == TWI_LAST_BIT);

    always_comb
    begin
        phase_nxt = twi_phase_t'(phase + 1'b1);
        bit_nxt   = last_phase ? twi_bit_t'(bit_idx + 1'b1) : bit_idx;
        shreg_nxt = shreg;
        if (op == WRITE_BYTE && last_phase)
            shreg_nxt = {shreg[6:0], 1'b0};
        if (op == READ_BYTE && phase == TWI_SAMPLE_PHASE && bit_idx != TWI_LAST_BIT)
            shreg_nxt = {shreg[6:0], sda_in};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= ENG_IDLE;
            qcnt    <= '0;
            phase   <= '0;
            bit_idx <= '0;
            done    <= 1'b0;
            line_q  <= TWI_LINE_IDLE;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                ENG_IDLE:
                begin
                    if (cmd_start)
                    begin
                        state   <= ENG_RUN;
                        qcnt    <= '0;
                        phase   <= '0;
                        bit_idx <= '0;
                        line_q  <= line_for(cmd.op, 2'd0, 4'd0, cmd.data[7], line_q.scl);
                    end
                end
                default:
                begin
                    if (!step_end)
                        qcnt <= twi_qcnt_t'(qcnt + 1'b1);
                    else if (last_phase && last_bit)
                    begin
                        qcnt  <= '0;
                        state <= ENG_IDLE;
                        done  <= 1'b1;      // lines hold their last level
                    end
                    else
                    begin
                        qcnt    <= '0;
                        phase   <= phase_nxt;
                        bit_idx <= bit_nxt;
                        line_q  <= line_for(op, phase_nxt, bit_nxt, shreg_nxt[7], line_q.scl);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == ENG_IDLE && cmd_start)
        begin
            op    <= cmd.op;
            shreg <= cmd.data;
        end
        else if (state == ENG_RUN && step_end)
            shreg <= shreg_nxt;
    end

    assign rx_byte = shreg;
    assign scl     = line_q.scl;
    assign sda_oe  = line_q.oe;
    assign sda_out = line_q.out;

endmodule

/* twi_pkg.sv */
package twi_pkg;

    import eeprom_pkg::*;

    typedef enum logic [1:0] {
        START      = 2'd0,
        STOP       = 2'd1,
        WRITE_BYTE = 2'd2,
        READ_BYTE  = 2'd3
    } twi_op_t;

    typedef struct packed {
        twi_op_t  op;
        ee_data_t data;     // only used by WRITE_BYTE
    } twi_cmd_t;

    // line levels as driven by the master
    typedef struct packed {
        logic scl;
        logic oe;
        logic out;
    } twi_line_t;

    localparam twi_line_t TWI_LINE_IDLE = '{scl: 1'b1, oe: 1'b0, out: 1'b1};

    // CLK cycles per quarter of an SCL period
    localparam int TWI_QUARTER = 1;
    localparam int TWI_QCNT_W  = (TWI_QUARTER > 1) ? $clog2(TWI_QUARTER) : 1;

    typedef logic [TWI_QCNT_W-1:0] twi_qcnt_t;
    typedef logic [1:0]            twi_phase_t;
    typedef logic [3:0]            twi_bit_t;

    localparam twi_qcnt_t  TWI_QCNT_LAST    = twi_qcnt_t'(TWI_QUARTER - 1);
    localparam twi_phase_t TWI_LAST_PHASE   = 2'd3;
    localparam twi_phase_t TWI_SAMPLE_PHASE = 2'd1;     // sample as phase 1 ends, mid high
    localparam twi_bit_t   TWI_LAST_BIT     = 4'd8;     // ninth clock is the ack bit

endpackage
